// ==== compile.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_issue_queue.sv
logic/cpu_regfile.sv
logic/cpu_decode.sv
logic/cpu_execute.sv
logic/cpu_core.sv
bench/cpu_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpu_core_tb
FILELIST ?= compile.f
BUILD_DIR ?= build
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/cpu_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module cpu_core_tb;
	import cpu_pkg::*;

	typedef struct packed {
		logic [`CPU_TAG_W-1:0] tag;
		logic [4:0] inst_rd;
		logic [31:0] rd;
		logic branch;
		logic [31:0] pc_next;
		logic mem_read;
		logic mem_write;
		mem_width_e width;
		logic mem_signed;
		logic [31:0] address;
	} result_t;

	logic clock;
	logic rst_n;
	logic issue_valid;
	logic [`CPU_TAG_W-1:0] issue_tag;
	logic [31:0] issue_pc;
	logic [31:0] issue_instruction;
	logic issue_credit;
	logic result_credit;
	logic result_valid;
	logic [`CPU_TAG_W-1:0] tag;
	logic [4:0] inst_rd;
	logic [31:0] rd;
	logic branch;
	logic [31:0] pc_next;
	logic mem_read;
	logic mem_write;
	mem_width_e mem_width;
	logic mem_signed;
	logic [31:0] mem_address;

	logic [31:0] shadow [32]; // Architectural registers as the program should leave them.
	result_t expected [1024];
	logic [31:0] rand_state = 32'h55f3;
	logic hold_result_credits;
	int issued_count;
	int results_seen;
	int credits_returned;
	int issue_credit_seen;
	int cycle_count;
	int value_errors;
	int other_errors;

	cpu_core i_cpu_core (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_issue_valid(issue_valid),
		.i_issue_tag(issue_tag),
		.i_issue_pc(issue_pc),
		.i_issue_instruction(issue_instruction),
		.o_issue_credit(issue_credit),
		.i_result_credit(result_credit),
		.o_result_valid(result_valid),
		.o_tag(tag),
		.o_inst_rd(inst_rd),
		.o_rd(rd),
		.o_branch(branch),
		.o_pc_next(pc_next),
		.o_mem_read(mem_read),
		.o_mem_write(mem_write),
		.o_mem_width(mem_width),
		.o_mem_signed(mem_signed),
		.o_mem_address(mem_address)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] random_word();
		rand_state = xorshift(rand_state);
		return rand_state;
	endfunction

	function automatic logic [31:0] random_imm12();
		logic [31:0] r;
		r = random_word();
		return {{20{r[11]}}, r[11:0]};
	endfunction

	function automatic logic [4:0] random_reg();
		return 5'(1 + random_word() % 8); // Picks one of x1 to x8.
	endfunction

	function automatic int upstream_credits();
		return `CPU_QUEUE_DEPTH - issued_count + issue_credit_seen;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] actual,
		input logic [31:0] want);
		if (actual !== want) begin
			$display("Fail %s: got 0x%08h, expected 0x%08h", name, actual, want);
			value_errors++;
		end
	endtask

	task automatic compare_width(input string name, input mem_width_e actual,
		input mem_width_e want);
		if (actual !== want) begin
			$display("Fail %s: got 0x%01h, expected 0x%01h", name, actual, want);
			value_errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic actual, input logic want);
		if (actual !== want) begin
			$display("Fail %s: got 0x%01h, expected 0x%01h", name, actual, want);
			value_errors++;
		end
	endtask

	// Builds the RV32I encoding of one operation from its fields.
	function automatic logic [31:0] encode(input op_e op, input logic [4:0] dest,
		input logic [4:0] src1, input logic [4:0] src2, input logic [31:0] imm);
		logic [2:0] f3;
		logic [6:0] f7;
		case (op)
			OP_BEQ, OP_LB, OP_SB, OP_ADDI, OP_ADD, OP_SUB, OP_JALR: f3 = 3'b000;
			OP_BNE, OP_LH, OP_SH, OP_SLLI, OP_SLL: f3 = 3'b001;
			OP_LW, OP_SW, OP_SLTI, OP_SLT: f3 = 3'b010;
			OP_SLTIU, OP_SLTU: f3 = 3'b011;
			OP_BLT, OP_LBU, OP_XORI, OP_XOR: f3 = 3'b100;
			OP_BGE, OP_LHU, OP_SRLI, OP_SRAI, OP_SRL, OP_SRA: f3 = 3'b101;
			OP_BLTU, OP_ORI, OP_OR: f3 = 3'b110;
			default: f3 = 3'b111;
		endcase
		f7 = (op inside {OP_SUB, OP_SRA, OP_SRAI}) ? 7'b0100000 : 7'b0000000;
		case (op)
			OP_LUI: return {imm[31:12], dest, 7'b0110111};
			OP_AUIPC: return {imm[31:12], dest, 7'b0010111};
			OP_JAL: return {imm[20], imm[10:1], imm[11], imm[19:12], dest, 7'b1101111};
			OP_JALR: return {imm[11:0], src1, f3, dest, 7'b1100111};
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
				return {imm[12], imm[10:5], src2, src1, f3, imm[4:1], imm[11], 7'b1100011};
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
				return {imm[11:0], src1, f3, dest, 7'b0000011};
			OP_SB, OP_SH, OP_SW:
				return {imm[11:5], src2, src1, f3, imm[4:0], 7'b0100011};
			OP_SLLI, OP_SRLI, OP_SRAI:
				return {f7, imm[4:0], src1, f3, dest, 7'b0010011};
			OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI:
				return {imm[11:0], src1, f3, dest, 7'b0010011};
			default: return {f7, src2, src1, f3, dest, 7'b0110011};
		endcase
	endfunction

	// Predicts the result record from the shadow registers, then sends the instruction.
	task automatic issue_op(input op_e op, input logic [4:0] dest, input logic [4:0] src1,
		input logic [4:0] src2, input logic [31:0] imm);
		result_t exp;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pc;
		logic [31:0] value;
		logic taken;
		logic writes;
		a = shadow[src1];
		b = shadow[src2];
		pc = 32'h1000 + 32'(issued_count) * 4;
		value = '0;
		taken = 1'b0;
		writes = 1'b1;
		case (op)
			OP_LUI: value = imm;
			OP_AUIPC: value = pc + imm;
			OP_JAL, OP_JALR: begin
				value = pc + 4;
				taken = 1'b1;
			end
			OP_BEQ: taken = (a == b);
			OP_BNE: taken = (a != b);
			OP_BLT: taken = ($signed(a) < $signed(b));
			OP_BGE: taken = ($signed(a) >= $signed(b));
			OP_BLTU: taken = (a < b);
			OP_BGEU: taken = (a >= b);
			OP_SB, OP_SH, OP_SW: value = b; // Store data rides on the result field.
			OP_ADD: value = a + b;
			OP_SUB: value = a - b;
			OP_ADDI: value = a + imm;
			OP_SLT: value = {31'd0, $signed(a) < $signed(b)};
			OP_SLTI: value = {31'd0, $signed(a) < $signed(imm)};
			OP_SLTU: value = {31'd0, a < b};
			OP_SLTIU: value = {31'd0, a < imm};
			OP_XOR: value = a ^ b;
			OP_XORI: value = a ^ imm;
			OP_OR: value = a | b;
			OP_ORI: value = a | imm;
			OP_AND: value = a & b;
			OP_ANDI: value = a & imm;
			OP_SLL: value = a << b[4:0];
			OP_SLLI: value = a << imm[4:0];
			OP_SRL: value = a >> b[4:0];
			OP_SRLI: value = a >> imm[4:0];
			OP_SRA: value = $signed(a) >>> b[4:0];
			OP_SRAI: value = $signed(a) >>> imm[4:0];
			default: value = '0;
		endcase
		if (op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_LB, OP_LH,
			OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW})
			writes = 1'b0;
		exp.tag = `CPU_TAG_W'(issued_count);
		exp.inst_rd = (op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
			OP_SB, OP_SH, OP_SW}) ? 5'd0 : dest;
		exp.rd = value;
		exp.branch = taken;
		if (!taken)
			exp.pc_next = pc + 4;
		else if (op == OP_JALR)
			exp.pc_next = (a + imm) & ~32'd1;
		else
			exp.pc_next = pc + imm;
		exp.mem_read = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
		exp.mem_write = op inside {OP_SB, OP_SH, OP_SW};
		case (op)
			OP_LB, OP_LBU, OP_SB: exp.width = MW_BYTE;
			OP_LH, OP_LHU, OP_SH: exp.width = MW_HALF;
			OP_LW, OP_SW: exp.width = MW_WORD;
			default: exp.width = MW_NONE;
		endcase
		exp.mem_signed = op inside {OP_LB, OP_LH};
		exp.address = a + imm;
		if (writes && dest != 5'd0)
			shadow[dest] = value;
		expected[issued_count] = exp;

		while (upstream_credits() <= 0) begin
			@(posedge clock);
			#2;
		end
		issue_valid = 1'b1;
		issue_tag = `CPU_TAG_W'(issued_count);
		issue_pc = pc;
		issue_instruction = encode(op, dest, src1, src2, imm);
		issued_count++;
		@(posedge clock);
		#2;
		issue_valid = 1'b0;
	endtask

	task automatic check_result(input result_t exp);
		compare_word("o_tag", 32'(tag), 32'(exp.tag));
		compare_word("o_inst_rd", 32'(inst_rd), 32'(exp.inst_rd));
		compare_word("o_rd", rd, exp.rd);
		compare_bit("o_branch", branch, exp.branch);
		compare_word("o_pc_next", pc_next, exp.pc_next);
		compare_bit("o_mem_read", mem_read, exp.mem_read);
		compare_bit("o_mem_write", mem_write, exp.mem_write);
		compare_width("o_mem_width", mem_width, exp.width);
		if (exp.mem_read || exp.mem_write) begin
			compare_bit("o_mem_signed", mem_signed, exp.mem_signed);
			compare_word("o_mem_address", mem_address, exp.address);
		end
	endtask

	// Outputs are registered, so the falling edge sees them settled.
	initial begin
		forever begin
			@(negedge clock);
			if (rst_n) begin
				if (issue_credit)
					issue_credit_seen++;
				if (result_valid) begin
					if (results_seen >= issued_count) begin
						$display("Result with tag 0x%02h arrived with no instruction outstanding",
							tag);
						other_errors++;
					end else begin
						check_result(expected[results_seen]);
					end
					results_seen++;
				end
			end
		end
	end

	// Downstream hands back one credit per cycle for each result it has taken.
	initial begin
		result_credit = 1'b0;
		forever begin
			@(posedge clock);
			#2;
			if (!hold_result_credits && credits_returned < results_seen) begin
				result_credit = 1'b1;
				credits_returned++;
			end else begin
				result_credit = 1'b0;
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count <= 40 * issued_count + 500) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout after %0d cycles with %0d of %0d results received", cycle_count,
			results_seen, issued_count);
		$display("=== FAIL ===");
		$finish;
	end

	task automatic wait_idle();
		while (results_seen != issued_count || credits_returned != results_seen ||
			upstream_credits() != `CPU_QUEUE_DEPTH) begin
			@(posedge clock);
			#2;
		end
		@(posedge clock); // Lets the last returned credit land in the DUT.
		#2;
	endtask

	task automatic test_reset();
		compare_bit("o_result_valid", result_valid, 1'b0);
		compare_bit("o_issue_credit", issue_credit, 1'b0);
		compare_bit("o_mem_read", mem_read, 1'b0);
		compare_bit("o_mem_write", mem_write, 1'b0);
		compare_bit("o_branch", branch, 1'b0);
		issue_op(OP_ADDI, 5'd6, 5'd5, 5'd0, 32'd0);
		wait_idle();
	endtask

	task automatic test_alu();
		logic [31:0] r;
		for (int i = 1; i <= 4; i++) begin
			r = random_word();
			issue_op(OP_LUI, 5'(i), 5'd0, 5'd0, {r[31:12], 12'd0});
		end
		for (int i = 1; i <= 8; i++)
			issue_op(OP_ADDI, 5'(i), 5'(i), 5'd0, random_imm12());
		for (int i = 0; i < 10; i++)
			issue_op(op_e'(OP_ADD + i), 5'(9 + i), random_reg(), random_reg(), 32'd0);
		issue_op(OP_SLTI, 5'd20, random_reg(), 5'd0, random_imm12());
		issue_op(OP_SLTIU, 5'd21, random_reg(), 5'd0, random_imm12());
		issue_op(OP_XORI, 5'd22, random_reg(), 5'd0, random_imm12());
		issue_op(OP_ORI, 5'd23, random_reg(), 5'd0, random_imm12());
		issue_op(OP_ANDI, 5'd24, random_reg(), 5'd0, random_imm12());
		r = random_word();
		issue_op(OP_SLLI, 5'd25, random_reg(), 5'd0, {27'd0, r[4:0]});
		r = random_word();
		issue_op(OP_SRLI, 5'd26, random_reg(), 5'd0, {27'd0, r[4:0]});
		r = random_word();
		issue_op(OP_SRAI, 5'd27, random_reg(), 5'd0, {27'd0, r[4:0]});
		r = random_word();
		issue_op(OP_AUIPC, 5'd28, 5'd0, 5'd0, {r[31:12], 12'd0});
		issue_op(OP_ADDI, 5'd0, 5'd1, 5'd0, 32'd123); // x0 must stay zero.
		issue_op(OP_ADD, 5'd29, 5'd0, 5'd1, 32'd0);
		issue_op(OP_ADDI, 5'd30, 5'd0, 5'd0, 32'd0);
		wait_idle();
	endtask

	task automatic test_branch_jump();
		issue_op(OP_ADDI, 5'd1, 5'd0, 5'd0, 32'd5);
		issue_op(OP_ADDI, 5'd2, 5'd0, 5'd0, 32'd5);
		issue_op(OP_ADDI, 5'd3, 5'd0, 5'd0, -32'sd3);
		issue_op(OP_ADDI, 5'd4, 5'd0, 5'd0, 32'd7);
		issue_op(OP_BEQ, 5'd0, 5'd1, 5'd2, 32'd16);
		issue_op(OP_BEQ, 5'd0, 5'd1, 5'd4, 32'd16);
		issue_op(OP_BNE, 5'd0, 5'd1, 5'd4, -32'sd8);
		issue_op(OP_BNE, 5'd0, 5'd1, 5'd2, -32'sd8);
		issue_op(OP_BLT, 5'd0, 5'd3, 5'd1, 32'd100);
		issue_op(OP_BLT, 5'd0, 5'd1, 5'd3, 32'd100);
		issue_op(OP_BGEU, 5'd0, 5'd3, 5'd1, -32'sd4096); // Negative rs1 is large unsigned.
		issue_op(OP_BGEU, 5'd0, 5'd1, 5'd3, 32'd4094);
		issue_op(OP_JAL, 5'd5, 5'd0, 5'd0, 32'd2048);
		issue_op(OP_JALR, 5'd6, 5'd4, 5'd0, 32'd13);
		issue_op(OP_ADD, 5'd7, 5'd5, 5'd6, 32'd0);
		wait_idle();
	endtask

	task automatic test_memory();
		logic [31:0] r;
		r = random_word();
		issue_op(OP_ADDI, 5'd1, 5'd0, 5'd0, 32'd256);
		issue_op(OP_LUI, 5'd2, 5'd0, 5'd0, {r[31:12], 12'd0});
		issue_op(OP_ADDI, 5'd2, 5'd2, 5'd0, random_imm12());
		issue_op(OP_LB, 5'd10, 5'd1, 5'd0, -32'sd4);
		issue_op(OP_LH, 5'd11, 5'd1, 5'd0, 32'd6);
		issue_op(OP_LW, 5'd12, 5'd1, 5'd0, 32'd8);
		issue_op(OP_LBU, 5'd13, 5'd1, 5'd0, 32'd1);
		issue_op(OP_LHU, 5'd14, 5'd1, 5'd0, 32'd2047);
		issue_op(OP_SB, 5'd0, 5'd1, 5'd2, -32'sd1);
		issue_op(OP_SH, 5'd0, 5'd1, 5'd2, 32'd10);
		issue_op(OP_SW, 5'd0, 5'd1, 5'd2, -32'sd2048);
		issue_op(OP_ADD, 5'd15, 5'd10, 5'd0, 32'd0); // Load targets keep their old values.
		issue_op(OP_ADD, 5'd16, 5'd14, 5'd0, 32'd0);
		wait_idle();
	endtask

	task automatic test_credits();
		int results_before;
		int credits_before;
		results_before = results_seen;
		credits_before = issue_credit_seen;
		hold_result_credits = 1'b1;
		for (int i = 0; i < `CPU_QUEUE_DEPTH; i++)
			issue_op(OP_ADDI, 5'(20 + i), 5'(20 + i), 5'd0, 32'(i + 1));
		repeat (20) begin
			@(posedge clock);
			#2;
		end
		compare_word("results with credits withheld", 32'(results_seen - results_before),
			32'(`CPU_RESULT_CREDITS));
		compare_word("o_issue_credit pulses with credits withheld",
			32'(issue_credit_seen - credits_before), 32'(`CPU_RESULT_CREDITS));
		hold_result_credits = 1'b0;
		wait_idle();
		compare_word("o_issue_credit pulses in total", 32'(issue_credit_seen - credits_before),
			32'(`CPU_QUEUE_DEPTH));
	endtask

	initial begin
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue_tag = '0;
		issue_pc = '0;
		issue_instruction = '0;
		hold_result_credits = 1'b0;
		issued_count = 0;
		results_seen = 0;
		credits_returned = 0;
		issue_credit_seen = 0;
		value_errors = 0;
		other_errors = 0;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;
		repeat (10) @(posedge clock);
		#2;
		rst_n = 1'b1;

		test_reset();
		test_alu();
		test_branch_jump();
		test_memory();
		test_credits();
		wait_idle();

		$display("Errors: %0d value mismatches, %0d other failures in %0d results",
			value_errors, other_errors, results_seen);
		if (value_errors == 0 && other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module cpu_core (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_issue_valid,
	input wire [`CPU_TAG_W-1:0] i_issue_tag,
	input wire [`CPU_XLEN-1:0] i_issue_pc,
	input wire [`CPU_XLEN-1:0] i_issue_instruction,
	output logic o_issue_credit,
	input wire i_result_credit,
	output logic o_result_valid,
	output logic [`CPU_TAG_W-1:0] o_tag,
	output logic [4:0] o_inst_rd,
	output logic [`CPU_XLEN-1:0] o_rd,
	output logic o_branch,
	output logic [`CPU_XLEN-1:0] o_pc_next,
	output logic o_mem_read,
	output logic o_mem_write,
	output cpu_pkg::mem_width_e o_mem_width,
	output logic o_mem_signed,
	output logic [`CPU_XLEN-1:0] o_mem_address
);
	import cpu_pkg::*;

	logic head_valid;
	logic head_pop;
	logic [`CPU_TAG_W-1:0] head_tag;
	logic [`CPU_XLEN-1:0] head_pc;
	logic [`CPU_XLEN-1:0] head_instruction;
	op_e op;
	logic [4:0] rs1_addr;
	logic [4:0] rs2_addr;
	logic [4:0] inst_rd;
	logic [`CPU_XLEN-1:0] imm;
	logic [`CPU_XLEN-1:0] rs1_data;
	logic [`CPU_XLEN-1:0] rs2_data;
	logic wr_en;
	logic [4:0] wr_addr;
	logic [`CPU_XLEN-1:0] wr_data;

	cpu_issue_queue i_cpu_issue_queue (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_wr_valid(i_issue_valid),
		.i_wr_tag(i_issue_tag),
		.i_wr_pc(i_issue_pc),
		.i_wr_instruction(i_issue_instruction),
		.i_pop(head_pop),
		.o_head_valid(head_valid),
		.o_head_tag(head_tag),
		.o_head_pc(head_pc),
		.o_head_instruction(head_instruction),
		.o_credit(o_issue_credit)
	);

	cpu_decode i_cpu_decode (
		.i_instruction(head_instruction),
		.o_op(op),
		.o_rs1_addr(rs1_addr),
		.o_rs2_addr(rs2_addr),
		.o_inst_rd(inst_rd),
		.o_imm(imm)
	);

	cpu_regfile i_cpu_regfile (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_rs1_addr(rs1_addr),
		.i_rs2_addr(rs2_addr),
		.i_wr_en(wr_en),
		.i_wr_addr(wr_addr),
		.i_wr_data(wr_data),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data)
	);

	cpu_execute i_cpu_execute (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_head_valid(head_valid),
		.i_tag(head_tag),
		.i_pc(head_pc),
		.i_op(op),
		.i_rs1(rs1_data),
		.i_rs2(rs2_data),
		.i_inst_rd(inst_rd),
		.i_imm(imm),
		.i_result_credit(i_result_credit),
		.o_pop(head_pop),
		.o_wr_en(wr_en),
		.o_wr_addr(wr_addr),
		.o_wr_data(wr_data),
		.o_result_valid(o_result_valid),
		.o_tag(o_tag),
		.o_inst_rd(o_inst_rd),
		.o_rd(o_rd),
		.o_branch(o_branch),
		.o_pc_next(o_pc_next),
		.o_mem_read(o_mem_read),
		.o_mem_write(o_mem_write),
		.o_mem_width(o_mem_width),
		.o_mem_signed(o_mem_signed),
		.o_mem_address(o_mem_address)
	);

endmodule

`default_nettype wire

// ==== logic/cpu_execute.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module cpu_execute (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_head_valid,
	input wire [`CPU_TAG_W-1:0] i_tag,
	input wire [`CPU_XLEN-1:0] i_pc,
	input wire cpu_pkg::op_e i_op,
	input wire [`CPU_XLEN-1:0] i_rs1,
	input wire [`CPU_XLEN-1:0] i_rs2,
	input wire [4:0] i_inst_rd,
	input wire [`CPU_XLEN-1:0] i_imm,
	input wire i_result_credit,
	output logic o_pop,
	output logic o_wr_en,
	output logic [4:0] o_wr_addr,
	output logic [`CPU_XLEN-1:0] o_wr_data,
	output logic o_result_valid,
	output logic [`CPU_TAG_W-1:0] o_tag,
	output logic [4:0] o_inst_rd,
	output logic [`CPU_XLEN-1:0] o_rd,
	output logic o_branch,
	output logic [`CPU_XLEN-1:0] o_pc_next,
	output logic o_mem_read,
	output logic o_mem_write,
	output cpu_pkg::mem_width_e o_mem_width,
	output logic o_mem_signed,
	output logic [`CPU_XLEN-1:0] o_mem_address
);
	import cpu_pkg::*;

	localparam int SHAMT_W = $clog2(`CPU_XLEN);
	localparam int CREDIT_W = $clog2(`CPU_RESULT_CREDITS + 1);

	logic [CREDIT_W-1:0] credits;
	logic [`CPU_XLEN-1:0] op_b;
	logic [SHAMT_W-1:0] shamt;
	logic [`CPU_XLEN-1:0] pc_plus4;
	logic [`CPU_XLEN-1:0] pc_target;
	logic [`CPU_XLEN-1:0] mem_address;
	logic [`CPU_XLEN-1:0] result;
	logic [`CPU_XLEN-1:0] pc_next;
	logic lt_signed;
	logic lt_unsigned;
	logic equal;
	logic taken;
	logic wb_en;
	logic mem_read;
	logic mem_write;
	logic mem_signed;
	mem_width_e mem_width;

	assign op_b = (i_op inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
		OP_SLLI, OP_SRLI, OP_SRAI}) ? i_imm : i_rs2;
	assign shamt = op_b[SHAMT_W-1:0];
	assign lt_signed = $signed(i_rs1) < $signed(op_b); // Branches compare against rs2.
	assign lt_unsigned = i_rs1 < op_b;
	assign equal = (i_rs1 == i_rs2);
	assign pc_plus4 = i_pc + `CPU_XLEN'd4;
	assign pc_target = i_pc + i_imm;
	assign mem_address = i_rs1 + i_imm;

	always_comb begin
		case (i_op)
			OP_LUI: result = i_imm;
			OP_AUIPC: result = pc_target;
			OP_JAL, OP_JALR: result = pc_plus4;
			OP_ADD, OP_ADDI: result = i_rs1 + op_b;
			OP_SUB: result = i_rs1 - i_rs2;
			OP_SLT, OP_SLTI: result = {{(`CPU_XLEN - 1){1'b0}}, lt_signed};
			OP_SLTU, OP_SLTIU: result = {{(`CPU_XLEN - 1){1'b0}}, lt_unsigned};
			OP_XOR, OP_XORI: result = i_rs1 ^ op_b;
			OP_OR, OP_ORI: result = i_rs1 | op_b;
			OP_AND, OP_ANDI: result = i_rs1 & op_b;
			OP_SLL, OP_SLLI: result = i_rs1 << shamt;
			OP_SRL, OP_SRLI: result = i_rs1 >> shamt;
			OP_SRA, OP_SRAI: result = $signed(i_rs1) >>> shamt;
			OP_SB, OP_SH, OP_SW: result = i_rs2; // Store data goes out on the result.
			default: result = '0;
		endcase
	end

	always_comb begin
		case (i_op)
			OP_BEQ: taken = equal;
			OP_BNE: taken = !equal;
			OP_BLT: taken = lt_signed;
			OP_BGE: taken = !lt_signed;
			OP_BLTU: taken = lt_unsigned;
			OP_BGEU: taken = !lt_unsigned;
			OP_JAL, OP_JALR: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (!taken)
			pc_next = pc_plus4;
		else if (i_op == OP_JALR)
			pc_next = {mem_address[`CPU_XLEN-1:1], 1'b0};
		else
			pc_next = pc_target;
	end

	always_comb begin
		case (i_op)
			OP_LB, OP_LBU, OP_SB: mem_width = MW_BYTE;
			OP_LH, OP_LHU, OP_SH: mem_width = MW_HALF;
			OP_LW, OP_SW: mem_width = MW_WORD;
			default: mem_width = MW_NONE;
		endcase
	end

	assign mem_read = i_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	assign mem_write = i_op inside {OP_SB, OP_SH, OP_SW};
	assign mem_signed = i_op inside {OP_LB, OP_LH};
	assign wb_en = !(i_op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU}) &&
		!mem_read && !mem_write && i_op != OP_ILLEGAL;

	assign o_pop = i_head_valid && (credits != '0);
	assign o_wr_en = o_pop && wb_en; // Loads are written back outside this slice.
	assign o_wr_addr = i_inst_rd;
	assign o_wr_data = result;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			credits <= CREDIT_W'(`CPU_RESULT_CREDITS);
		else if (o_pop && !i_result_credit)
			credits <= credits - 1'b1;
		else if (!o_pop && i_result_credit)
			credits <= credits + 1'b1;
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_result_valid <= 1'b0;
			o_tag <= '0;
			o_inst_rd <= '0;
			o_rd <= '0;
			o_branch <= 1'b0;
			o_pc_next <= '0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			o_mem_width <= MW_NONE;
			o_mem_signed <= 1'b0;
			o_mem_address <= '0;
		end else begin
			o_result_valid <= o_pop;
			if (o_pop) begin
				o_tag <= i_tag;
				o_inst_rd <= i_inst_rd;
				o_rd <= result;
				o_branch <= taken;
				o_pc_next <= pc_next;
				o_mem_read <= mem_read;
				o_mem_write <= mem_write;
				o_mem_width <= mem_width;
				o_mem_signed <= mem_signed;
				o_mem_address <= mem_address;
			end
		end
	end

	// Downstream must never hand back more credits than it was given.
	a_credit_bound: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		credits <= CREDIT_W'(`CPU_RESULT_CREDITS));

endmodule

`default_nettype wire

// ==== logic/cpu_decode.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module cpu_decode (
	input wire [31:0] i_instruction,
	output cpu_pkg::op_e o_op,
	output logic [4:0] o_rs1_addr,
	output logic [4:0] o_rs2_addr,
	output logic [4:0] o_inst_rd,
	output logic [`CPU_XLEN-1:0] o_imm
);
	import cpu_pkg::*;

	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign funct7 = i_instruction[31:25];

	assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
	assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
	assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
		i_instruction[30:25], i_instruction[11:8], 1'b0};
	assign imm_u = {i_instruction[31:12], 12'b0};
	assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
		i_instruction[20], i_instruction[30:21], 1'b0};

	assign o_rs1_addr = i_instruction[19:15];
	assign o_rs2_addr = i_instruction[24:20];

	always_comb begin
		o_op = OP_ILLEGAL;
		o_imm = '0;
		case (opcode)
			OPC_LUI: begin
				o_op = OP_LUI;
				o_imm = imm_u;
			end
			OPC_AUIPC: begin
				o_op = OP_AUIPC;
				o_imm = imm_u;
			end
			OPC_JAL: begin
				o_op = OP_JAL;
				o_imm = imm_j;
			end
			OPC_JALR: begin
				o_op = (funct3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
				o_imm = imm_i;
			end
			OPC_BRANCH: begin
				o_imm = imm_b;
				case (funct3)
					3'b000: o_op = OP_BEQ;
					3'b001: o_op = OP_BNE;
					3'b100: o_op = OP_BLT;
					3'b101: o_op = OP_BGE;
					3'b110: o_op = OP_BLTU;
					3'b111: o_op = OP_BGEU;
					default: o_op = OP_ILLEGAL;
				endcase
			end
			OPC_LOAD: begin
				o_imm = imm_i;
				case (funct3)
					3'b000: o_op = OP_LB;
					3'b001: o_op = OP_LH;
					3'b010: o_op = OP_LW;
					3'b100: o_op = OP_LBU;
					3'b101: o_op = OP_LHU;
					default: o_op = OP_ILLEGAL;
				endcase
			end
			OPC_STORE: begin
				o_imm = imm_s;
				case (funct3)
					3'b000: o_op = OP_SB;
					3'b001: o_op = OP_SH;
					3'b010: o_op = OP_SW;
					default: o_op = OP_ILLEGAL;
				endcase
			end
			OPC_OP_IMM: begin
				o_imm = imm_i; // Shift amounts sit in the low five bits.
				case (funct3)
					3'b000: o_op = OP_ADDI;
					3'b010: o_op = OP_SLTI;
					3'b011: o_op = OP_SLTIU;
					3'b100: o_op = OP_XORI;
					3'b110: o_op = OP_ORI;
					3'b111: o_op = OP_ANDI;
					3'b001: o_op = (funct7 == 7'b0000000) ? OP_SLLI : OP_ILLEGAL;
					default: begin
						if (funct7 == 7'b0000000)
							o_op = OP_SRLI;
						else if (funct7 == 7'b0100000)
							o_op = OP_SRAI;
					end
				endcase
			end
			OPC_OP: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: o_op = OP_ADD;
						3'b001: o_op = OP_SLL;
						3'b010: o_op = OP_SLT;
						3'b011: o_op = OP_SLTU;
						3'b100: o_op = OP_XOR;
						3'b101: o_op = OP_SRL;
						3'b110: o_op = OP_OR;
						default: o_op = OP_AND;
					endcase
				end else if (funct7 == 7'b0100000) begin
					if (funct3 == 3'b000)
						o_op = OP_SUB;
					else if (funct3 == 3'b101)
						o_op = OP_SRA;
				end
			end
			default: o_op = OP_ILLEGAL;
		endcase
	end

	// Branches, stores and illegal encodings have no destination register.
	assign o_inst_rd = (opcode == OPC_BRANCH || opcode == OPC_STORE || o_op == OP_ILLEGAL) ?
		5'd0 : i_instruction[11:7];

endmodule

`default_nettype wire

// ==== logic/cpu_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module cpu_regfile (
	input wire i_clock,
	input wire i_rst_n,
	input wire [4:0] i_rs1_addr,
	input wire [4:0] i_rs2_addr,
	input wire i_wr_en,
	input wire [4:0] i_wr_addr,
	input wire [`CPU_XLEN-1:0] i_wr_data,
	output logic [`CPU_XLEN-1:0] o_rs1_data,
	output logic [`CPU_XLEN-1:0] o_rs2_data
);

	logic [`CPU_XLEN-1:0] regs [32];

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (i_wr_en && i_wr_addr != 5'd0) begin
			regs[i_wr_addr] <= i_wr_data; // Writes to x0 are dropped.
		end
	end

	assign o_rs1_data = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
	assign o_rs2_data = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

// ==== logic/cpu_issue_queue.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module cpu_issue_queue (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_wr_valid,
	input wire [`CPU_TAG_W-1:0] i_wr_tag,
	input wire [`CPU_XLEN-1:0] i_wr_pc,
	input wire [`CPU_XLEN-1:0] i_wr_instruction,
	input wire i_pop,
	output logic o_head_valid,
	output logic [`CPU_TAG_W-1:0] o_head_tag,
	output logic [`CPU_XLEN-1:0] o_head_pc,
	output logic [`CPU_XLEN-1:0] o_head_instruction,
	output logic o_credit
);
	import cpu_pkg::*;

	localparam int DEPTH = `CPU_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [`CPU_TAG_W-1:0] tag_mem [DEPTH];
	logic [`CPU_XLEN-1:0] pc_mem [DEPTH];
	logic [`CPU_XLEN-1:0] instruction_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr_next;
	logic [PTR_W-1:0] rd_ptr_next;
	queue_state_e state;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign wr_ptr_next = ptr_inc(wr_ptr);
	assign rd_ptr_next = ptr_inc(rd_ptr);

	always_ff @(posedge i_clock) begin
		if (i_wr_valid) begin
			tag_mem[wr_ptr] <= i_wr_tag;
			pc_mem[wr_ptr] <= i_wr_pc;
			instruction_mem[wr_ptr] <= i_wr_instruction;
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			state <= QS_EMPTY;
			o_credit <= 1'b0;
		end else begin
			o_credit <= i_pop; // One credit back per popped entry.
			if (i_wr_valid)
				wr_ptr <= wr_ptr_next;
			if (i_pop)
				rd_ptr <= rd_ptr_next;
			if (i_wr_valid && !i_pop)
				state <= (wr_ptr_next == rd_ptr) ? QS_FULL : QS_PARTIAL;
			else if (i_pop && !i_wr_valid)
				state <= (rd_ptr_next == wr_ptr) ? QS_EMPTY : QS_PARTIAL;
		end
	end

	assign o_head_valid = (state != QS_EMPTY);
	assign o_head_tag = tag_mem[rd_ptr];
	assign o_head_pc = pc_mem[rd_ptr];
	assign o_head_instruction = instruction_mem[rd_ptr];

	// Upstream only writes while it holds a credit, so a full queue never sees a write.
	a_no_write_when_full: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_wr_valid |-> state != QS_FULL);

	a_no_pop_when_empty: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_pop |-> state != QS_EMPTY);

endmodule

`default_nettype wire

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef enum logic [5:0] {
		OP_LUI,
		OP_AUIPC,
		OP_JAL,
		OP_JALR,
		OP_BEQ,
		OP_BNE,
		OP_BLT,
		OP_BGE,
		OP_BLTU,
		OP_BGEU,
		OP_LB,
		OP_LH,
		OP_LW,
		OP_LBU,
		OP_LHU,
		OP_SB,
		OP_SH,
		OP_SW,
		OP_ADDI,
		OP_SLTI,
		OP_SLTIU,
		OP_XORI,
		OP_ORI,
		OP_ANDI,
		OP_SLLI,
		OP_SRLI,
		OP_SRAI,
		OP_ADD,
		OP_SUB,
		OP_SLL,
		OP_SLT,
		OP_SLTU,
		OP_XOR,
		OP_SRL,
		OP_SRA,
		OP_OR,
		OP_AND,
		OP_ILLEGAL
	} op_e;

	typedef enum logic [2:0] {
		MW_NONE = 3'd0,
		MW_BYTE = 3'd1,
		MW_HALF = 3'd2,
		MW_WORD = 3'd4 // Encoded as the access size in bytes.
	} mem_width_e;

	typedef enum logic [1:0] {
		QS_EMPTY,
		QS_PARTIAL,
		QS_FULL
	} queue_state_e;

endpackage

`default_nettype wire

// ==== logic/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width of the core.
`define CPU_XLEN 32

// Width of the label that travels with each instruction.
`define CPU_TAG_W 8

// Issue queue entries, which is also the number of credits upstream starts with.
`define CPU_QUEUE_DEPTH 4

// Credits the execute stage holds on its result port after reset.
`define CPU_RESULT_CREDITS 2

`endif
